// ==== common/kinpira_pkg.sv ====
`default_nettype none

package kinpira_pkg;

  // ========================================
  // Word and bus widths
  // ========================================

  // Activation, weight and bias words
  localparam int DWIDTH    = 16;
  localparam int ACC_WIDTH = 32;

  // Register bus
  localparam int BWIDTH  = 32;
  localparam int REGSIZE = 4;

  // Counts and packed layer fields
  localparam int LWIDTH = 16;

  // ========================================
  // Memory sizes
  // ========================================

  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 12;

  // Register word addresses
  typedef enum logic [REGSIZE-1:0] {
    REG_REQ        = 4'd0,
    REG_BASE       = 4'd1,
    REG_IN_OFFSET  = 4'd2,
    REG_OUT_OFFSET = 4'd3,
    REG_NET_OFFSET = 4'd4,
    REG_QBITS      = 4'd5,
    REG_BIAS       = 4'd6,
    REG_ACTV       = 4'd7,
    REG_STATUS     = 4'd8
  } reg_sel_t;

  // Layer sequencer
  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_DRAIN,
    S_WRITE,
    S_DONE
  } gobou_state_t;

endpackage

`default_nettype wire

// ==== hw/mem_sp.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sp #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                                  clk,
  input  logic                                  mem_we,
  input  logic [ADDR_WIDTH-1:0]                 mem_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] mem_wdata,
  output logic signed [kinpira_pkg::DWIDTH-1:0] mem_rdata
);
  import kinpira_pkg::*;

  logic signed [DWIDTH-1:0] mem [0:2**ADDR_WIDTH-1];

  // Read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule

`default_nettype wire

// ==== hw/param_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_regs (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               reg_we,
  input  logic                               reg_re,
  input  logic [kinpira_pkg::REGSIZE-1:0]    reg_addr,
  input  logic [kinpira_pkg::BWIDTH-1:0]     reg_wdata,
  input  logic                               busy,
  input  logic                               ack,
  output logic [kinpira_pkg::BWIDTH-1:0]     reg_rdata,
  output logic                               req,
  output logic [kinpira_pkg::LWIDTH-1:0]     total_in,
  output logic [kinpira_pkg::LWIDTH-1:0]     total_out,
  output logic [kinpira_pkg::IMGSIZE-1:0]    in_offset,
  output logic [kinpira_pkg::IMGSIZE-1:0]    out_offset,
  output logic [kinpira_pkg::NETSIZE-1:0]    net_offset,
  output logic [kinpira_pkg::LWIDTH-1:0]     qbits,
  output logic                               bias_en,
  output logic                               relu_en
);
  import kinpira_pkg::*;

  reg_sel_t          sel;
  logic [BWIDTH-1:0] req_word;
  logic [BWIDTH-1:0] base_word;
  logic [BWIDTH-1:0] in_off_word;
  logic [BWIDTH-1:0] out_off_word;
  logic [BWIDTH-1:0] net_off_word;
  logic [BWIDTH-1:0] qbits_word;
  logic [BWIDTH-1:0] bias_word;
  logic [BWIDTH-1:0] actv_word;

  assign sel = reg_sel_t'(reg_addr);

  // ========================================
  // Host writes
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req          <= 1'b0;
      req_word     <= '0;
      base_word    <= '0;
      in_off_word  <= '0;
      out_off_word <= '0;
      net_off_word <= '0;
      qbits_word   <= '0;
      bias_word    <= '0;
      actv_word    <= '0;
    end else begin
      // One-cycle start pulse
      req <= reg_we && (sel == REG_REQ) && reg_wdata[0];
      if (reg_we) begin
        case (sel)
          REG_REQ:        req_word     <= reg_wdata;
          REG_BASE:       base_word    <= reg_wdata;
          REG_IN_OFFSET:  in_off_word  <= reg_wdata;
          REG_OUT_OFFSET: out_off_word <= reg_wdata;
          REG_NET_OFFSET: net_off_word <= reg_wdata;
          REG_QBITS:      qbits_word   <= reg_wdata;
          REG_BIAS:       bias_word    <= reg_wdata;
          REG_ACTV:       actv_word    <= reg_wdata;
          default: ;
        endcase
      end
    end
  end

  // Registered readback, status is live
  always_ff @(posedge clk) begin
    if (!xrst) begin
      reg_rdata <= '0;
    end else if (reg_re) begin
      case (sel)
        REG_REQ:        reg_rdata <= req_word;
        REG_BASE:       reg_rdata <= base_word;
        REG_IN_OFFSET:  reg_rdata <= in_off_word;
        REG_OUT_OFFSET: reg_rdata <= out_off_word;
        REG_NET_OFFSET: reg_rdata <= net_off_word;
        REG_QBITS:      reg_rdata <= qbits_word;
        REG_BIAS:       reg_rdata <= bias_word;
        REG_ACTV:       reg_rdata <= actv_word;
        REG_STATUS:     reg_rdata <= {{(BWIDTH-2){1'b0}}, busy, ack};
        default:        reg_rdata <= '0;
      endcase
    end
  end

  // Field decode
  assign total_out  = base_word[2*LWIDTH-1:LWIDTH];
  assign total_in   = base_word[LWIDTH-1:0];
  assign in_offset  = in_off_word[IMGSIZE-1:0];
  assign out_offset = out_off_word[IMGSIZE-1:0];
  assign net_offset = net_off_word[NETSIZE-1:0];
  assign qbits      = qbits_word[LWIDTH-1:0];
  assign bias_en    = bias_word[BWIDTH-1];
  assign relu_en    = actv_word[BWIDTH-1];

endmodule

`default_nettype wire

// ==== gobou/gobou_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module gobou_mac (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic                                  acc_clear,
  input  logic                                  acc_en,
  input  logic                                  bias_add,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] mac_img,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] mac_net,
  input  logic [kinpira_pkg::LWIDTH-1:0]        qbits,
  input  logic                                  relu_en,
  output logic signed [kinpira_pkg::DWIDTH-1:0] result
);
  import kinpira_pkg::*;

  logic signed [2*DWIDTH-1:0]  product;
  logic signed [ACC_WIDTH-1:0] acc;
  logic signed [ACC_WIDTH-1:0] shifted;
  logic signed [ACC_WIDTH-1:0] rectified;

  assign product = mac_img * mac_net;

  // ========================================
  // Accumulator
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc <= '0;
    end else if (acc_clear) begin
      acc <= '0;
    end else if (acc_en) begin
      acc <= acc + ACC_WIDTH'(product);
    end else if (bias_add) begin
      // Bias word arrives on the weight port
      acc <= acc + ACC_WIDTH'(mac_net);
    end
  end

  // ========================================
  // Output stage
  // ========================================

  assign shifted   = acc >>> qbits;
  assign rectified = (relu_en && shifted[ACC_WIDTH-1]) ? '0 : shifted;

  // Clamp when the upper bits are not a plain sign extension
  always_comb begin
    if (&rectified[ACC_WIDTH-1:DWIDTH-1] || ~|rectified[ACC_WIDTH-1:DWIDTH-1]) begin
      result = rectified[DWIDTH-1:0];
    end else if (rectified[ACC_WIDTH-1]) begin
      result = {1'b1, {(DWIDTH-1){1'b0}}};
    end else begin
      result = {1'b0, {(DWIDTH-1){1'b1}}};
    end
  end

endmodule

`default_nettype wire

// ==== gobou/gobou_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gobou_ctrl (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic                                  req,
  input  logic [kinpira_pkg::LWIDTH-1:0]        total_in,
  input  logic [kinpira_pkg::LWIDTH-1:0]        total_out,
  input  logic [kinpira_pkg::IMGSIZE-1:0]       in_offset,
  input  logic [kinpira_pkg::IMGSIZE-1:0]       out_offset,
  input  logic [kinpira_pkg::NETSIZE-1:0]       net_offset,
  input  logic                                  bias_en,
  input  logic                                  img_we,
  input  logic [kinpira_pkg::IMGSIZE-1:0]       img_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] img_wdata,
  input  logic                                  net_we,
  input  logic [kinpira_pkg::NETSIZE-1:0]       net_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] net_wdata,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] mem_img_rdata,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] mem_net_rdata,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] result,
  output logic                                  busy,
  output logic                                  ack,
  output logic                                  mem_img_we,
  output logic [kinpira_pkg::IMGSIZE-1:0]       mem_img_addr,
  output logic signed [kinpira_pkg::DWIDTH-1:0] mem_img_wdata,
  output logic [kinpira_pkg::NETSIZE-1:0]       mem_net_addr,
  output logic                                  mem_net_we,
  output logic signed [kinpira_pkg::DWIDTH-1:0] mem_net_wdata,
  output logic signed [kinpira_pkg::DWIDTH-1:0] img_rdata,
  output logic signed [kinpira_pkg::DWIDTH-1:0] net_rdata,
  output logic                                  acc_clear,
  output logic                                  acc_en,
  output logic                                  bias_add,
  output logic signed [kinpira_pkg::DWIDTH-1:0] mac_img,
  output logic signed [kinpira_pkg::DWIDTH-1:0] mac_net
);
  import kinpira_pkg::*;

  gobou_state_t       state;
  logic [LWIDTH-1:0]  in_cnt;
  logic [LWIDTH-1:0]  out_cnt;
  logic [NETSIZE-1:0] net_base;
  logic               last_in;
  logic               last_out;
  logic               rd_issue;
  logic               bias_issue;
  logic [IMGSIZE-1:0] core_img_addr;
  logic [NETSIZE-1:0] core_net_addr;

  assign busy     = state != S_IDLE;
  assign last_in  = in_cnt == total_in;
  assign last_out = out_cnt == total_out - 1'b1;

  // ========================================
  // Sequencer
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= S_IDLE;
      in_cnt   <= '0;
      out_cnt  <= '0;
      net_base <= '0;
      ack      <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req) begin
            state    <= (total_out == '0) ? S_DONE : S_READ;
            in_cnt   <= '0;
            out_cnt  <= '0;
            net_base <= net_offset;
            ack      <= 1'b0;
          end
        end
        S_READ: begin
          // Last slot of each row is the bias word
          if (last_in) begin
            state <= S_DRAIN;
          end else begin
            in_cnt <= in_cnt + 1'b1;
          end
        end
        S_DRAIN: begin
          state <= S_WRITE;
        end
        S_WRITE: begin
          in_cnt <= '0;
          if (last_out) begin
            state <= S_DONE;
          end else begin
            state    <= S_READ;
            out_cnt  <= out_cnt + 1'b1;
            net_base <= net_base + total_in[NETSIZE-1:0] + 1'b1;
          end
        end
        S_DONE: begin
          state <= S_IDLE;
          ack   <= 1'b1;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Read issue, data lands one cycle later
  assign rd_issue   = (state == S_READ) && !last_in;
  assign bias_issue = (state == S_READ) && last_in && bias_en;
  assign acc_clear  = (state == S_READ) && (in_cnt == '0);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc_en   <= 1'b0;
      bias_add <= 1'b0;
    end else begin
      acc_en   <= rd_issue;
      bias_add <= bias_issue;
    end
  end

  // ========================================
  // Memory ports
  // ========================================

  assign core_img_addr = (state == S_WRITE) ? out_offset + out_cnt[IMGSIZE-1:0]
                                            : in_offset + in_cnt[IMGSIZE-1:0];
  assign core_net_addr = net_base + in_cnt[NETSIZE-1:0];

  // Host owns the memories only while idle
  always_comb begin
    if (busy) begin
      mem_img_we    = state == S_WRITE;
      mem_img_addr  = core_img_addr;
      mem_img_wdata = result;
      mem_net_we    = 1'b0;
      mem_net_addr  = core_net_addr;
      mem_net_wdata = '0;
    end else begin
      mem_img_we    = img_we;
      mem_img_addr  = img_addr;
      mem_img_wdata = img_wdata;
      mem_net_we    = net_we;
      mem_net_addr  = net_addr;
      mem_net_wdata = net_wdata;
    end
  end

  assign img_rdata = mem_img_rdata;
  assign net_rdata = mem_net_rdata;
  assign mac_img   = mem_img_rdata;
  assign mac_net   = mem_net_rdata;

endmodule

`default_nettype wire

// ==== hw/kinpira_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kinpira_top (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic                                  reg_we,
  input  logic                                  reg_re,
  input  logic [kinpira_pkg::REGSIZE-1:0]       reg_addr,
  input  logic [kinpira_pkg::BWIDTH-1:0]        reg_wdata,
  output logic [kinpira_pkg::BWIDTH-1:0]        reg_rdata,
  input  logic                                  img_we,
  input  logic [kinpira_pkg::IMGSIZE-1:0]       img_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] img_wdata,
  output logic signed [kinpira_pkg::DWIDTH-1:0] img_rdata,
  input  logic                                  net_we,
  input  logic [kinpira_pkg::NETSIZE-1:0]       net_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] net_wdata,
  output logic signed [kinpira_pkg::DWIDTH-1:0] net_rdata
);
  import kinpira_pkg::*;

  // ========================================
  // Layer parameters and status
  // ========================================

  logic               req;
  logic               busy;
  logic               ack;
  logic [LWIDTH-1:0]  total_in;
  logic [LWIDTH-1:0]  total_out;
  logic [IMGSIZE-1:0] in_offset;
  logic [IMGSIZE-1:0] out_offset;
  logic [NETSIZE-1:0] net_offset;
  logic [LWIDTH-1:0]  qbits;
  logic               bias_en;
  logic               relu_en;

  // Memory side
  logic                     mem_img_we;
  logic [IMGSIZE-1:0]       mem_img_addr;
  logic signed [DWIDTH-1:0] mem_img_wdata;
  logic signed [DWIDTH-1:0] mem_img_rdata;
  logic                     mem_net_we;
  logic [NETSIZE-1:0]       mem_net_addr;
  logic signed [DWIDTH-1:0] mem_net_wdata;
  logic signed [DWIDTH-1:0] mem_net_rdata;

  // MAC strobes
  logic                     acc_clear;
  logic                     acc_en;
  logic                     bias_add;
  logic signed [DWIDTH-1:0] mac_img;
  logic signed [DWIDTH-1:0] mac_net;
  logic signed [DWIDTH-1:0] result;

  param_regs u_regs (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .busy       (busy),
    .ack        (ack),
    .reg_rdata  (reg_rdata),
    .req        (req),
    .total_in   (total_in),
    .total_out  (total_out),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .qbits      (qbits),
    .bias_en    (bias_en),
    .relu_en    (relu_en)
  );

  mem_sp #(.ADDR_WIDTH(IMGSIZE)) mem_img (
    .clk       (clk),
    .mem_we    (mem_img_we),
    .mem_addr  (mem_img_addr),
    .mem_wdata (mem_img_wdata),
    .mem_rdata (mem_img_rdata)
  );

  mem_sp #(.ADDR_WIDTH(NETSIZE)) mem_net (
    .clk       (clk),
    .mem_we    (mem_net_we),
    .mem_addr  (mem_net_addr),
    .mem_wdata (mem_net_wdata),
    .mem_rdata (mem_net_rdata)
  );

  // ========================================
  // Fully connected core
  // ========================================

  gobou_ctrl u_ctrl (
    .clk           (clk),
    .xrst          (xrst),
    .req           (req),
    .total_in      (total_in),
    .total_out     (total_out),
    .in_offset     (in_offset),
    .out_offset    (out_offset),
    .net_offset    (net_offset),
    .bias_en       (bias_en),
    .img_we        (img_we),
    .img_addr      (img_addr),
    .img_wdata     (img_wdata),
    .net_we        (net_we),
    .net_addr      (net_addr),
    .net_wdata     (net_wdata),
    .mem_img_rdata (mem_img_rdata),
    .mem_net_rdata (mem_net_rdata),
    .result        (result),
    .busy          (busy),
    .ack           (ack),
    .mem_img_we    (mem_img_we),
    .mem_img_addr  (mem_img_addr),
    .mem_img_wdata (mem_img_wdata),
    .mem_net_addr  (mem_net_addr),
    .mem_net_we    (mem_net_we),
    .mem_net_wdata (mem_net_wdata),
    .img_rdata     (img_rdata),
    .net_rdata     (net_rdata),
    .acc_clear     (acc_clear),
    .acc_en        (acc_en),
    .bias_add      (bias_add),
    .mac_img       (mac_img),
    .mac_net       (mac_net)
  );

  gobou_mac u_mac (
    .clk       (clk),
    .xrst      (xrst),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .bias_add  (bias_add),
    .mac_img   (mac_img),
    .mac_net   (mac_net),
    .qbits     (qbits),
    .relu_en   (relu_en),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== test/kinpira_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module kinpira_checker (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic                                  busy,
  input  logic [8*16-1:0]                       test_name,
  input  logic                                  reg_we,
  input  logic                                  reg_re,
  input  logic [kinpira_pkg::REGSIZE-1:0]       reg_addr,
  input  logic [kinpira_pkg::BWIDTH-1:0]        reg_wdata,
  input  logic [kinpira_pkg::BWIDTH-1:0]        reg_rdata,
  input  logic                                  img_we,
  input  logic                                  img_rd,
  input  logic [kinpira_pkg::IMGSIZE-1:0]       img_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] img_wdata,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] img_rdata,
  input  logic                                  net_we,
  input  logic                                  net_rd,
  input  logic [kinpira_pkg::NETSIZE-1:0]       net_addr,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] net_wdata,
  input  logic signed [kinpira_pkg::DWIDTH-1:0] net_rdata,
  output int                                    error_count,
  output int                                    check_count
);
  import kinpira_pkg::*;

  localparam longint SAT_MAX = 2**(DWIDTH-1) - 1;
  localparam longint SAT_MIN = -(2**(DWIDTH-1));

  typedef enum int {PH_IDLE, PH_RUN, PH_DONE} phase_t;

  logic [BWIDTH-1:0]        reg_model [0:15];
  logic signed [DWIDTH-1:0] img_model [0:2**IMGSIZE-1];
  logic signed [DWIDTH-1:0] net_model [0:2**NETSIZE-1];
  phase_t                   phase;
  logic                     seen_busy;
  logic                     reg_pend;
  logic [REGSIZE-1:0]       reg_pend_addr;
  logic [BWIDTH-1:0]        reg_pend_exp;
  logic                     img_pend;
  logic [IMGSIZE-1:0]       img_pend_addr;
  logic                     net_pend;
  logic [NETSIZE-1:0]       net_pend_addr;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  // ========================================
  // Reference model
  // ========================================

  function automatic logic signed [DWIDTH-1:0] ref_output(input int o);
    longint sum;
    int     tin;
    int     in_off;
    int     row;
    tin    = int'(reg_model[REG_BASE][LWIDTH-1:0]);
    in_off = int'(reg_model[REG_IN_OFFSET][IMGSIZE-1:0]);
    row    = int'(reg_model[REG_NET_OFFSET][NETSIZE-1:0]) + o * (tin + 1);
    sum    = 0;
    for (int i = 0; i < tin; i++) begin
      sum += longint'(img_model[in_off + i]) * longint'(net_model[row + i]);
    end
    // Bias sits in the last slot of the row
    if (reg_model[REG_BIAS][BWIDTH-1]) begin
      sum += longint'(net_model[row + tin]);
    end
    sum = sum >>> reg_model[REG_QBITS][LWIDTH-1:0];
    if (reg_model[REG_ACTV][BWIDTH-1] && sum < 0) begin
      sum = 0;
    end
    if (sum > SAT_MAX) begin
      sum = SAT_MAX;
    end else if (sum < SAT_MIN) begin
      sum = SAT_MIN;
    end
    return sum[DWIDTH-1:0];
  endfunction

  function automatic logic [BWIDTH-1:0] expected_reg(input logic [REGSIZE-1:0] addr);
    if (addr != REG_STATUS) begin
      return reg_model[addr];
    end
    case (phase)
      PH_RUN:  return 32'd2;
      PH_DONE: return 32'd1;
      default: return 32'd0;
    endcase
  endfunction

  task automatic start_layer();
    int tout;
    int out_off;
    tout    = int'(reg_model[REG_BASE][BWIDTH-1:LWIDTH]);
    out_off = int'(reg_model[REG_OUT_OFFSET][IMGSIZE-1:0]);
    for (int o = 0; o < tout; o++) begin
      img_model[out_off + o] = ref_output(o);
    end
    phase     = PH_RUN;
    seen_busy = 1'b0;
  endtask

  task automatic compare(input string what, input logic signed [63:0] expected,
                         input logic signed [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %0s: %0s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  // ========================================
  // Port monitor
  // ========================================

  always @(posedge clk) begin
    if (!xrst) begin
      phase     = PH_IDLE;
      seen_busy = 1'b0;
      reg_pend  = 1'b0;
      img_pend  = 1'b0;
      net_pend  = 1'b0;
      for (int a = 0; a < 16; a++) begin
        reg_model[a] = '0;
      end
    end else begin
      // Read data from the previous edge
      if (reg_pend) begin
        compare($sformatf("reg %0d", reg_pend_addr), reg_pend_exp, reg_rdata);
      end
      if (img_pend) begin
        compare($sformatf("img[%0d]", img_pend_addr), img_model[img_pend_addr], img_rdata);
      end
      if (net_pend) begin
        compare($sformatf("net[%0d]", net_pend_addr), net_model[net_pend_addr], net_rdata);
      end

      // Run ends when busy falls
      if (phase == PH_RUN) begin
        if (busy) begin
          seen_busy = 1'b1;
        end else if (seen_busy) begin
          phase = PH_DONE;
        end
      end

      reg_pend      = reg_re;
      reg_pend_addr = reg_addr;
      reg_pend_exp  = expected_reg(reg_addr);
      img_pend      = img_rd && !img_we && !busy;
      img_pend_addr = img_addr;
      net_pend      = net_rd && !net_we && !busy;
      net_pend_addr = net_addr;

      if (reg_we && reg_addr == REG_REQ && reg_wdata[0] && !busy) begin
        start_layer();
      end
      if (reg_we && reg_addr < REG_STATUS) begin
        reg_model[reg_addr] = reg_wdata;
      end
      if (img_we && !busy) begin
        img_model[img_addr] = img_wdata;
      end
      if (net_we && !busy) begin
        net_model[net_addr] = net_wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/kinpira_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kinpira_tb;
  import kinpira_pkg::*;

  localparam int RST_CYCLES   = 16;
  localparam int SETUP_CYCLES = 2000;

  logic                     clk;
  logic                     xrst;
  logic                     reg_we;
  logic                     reg_re;
  logic [REGSIZE-1:0]       reg_addr;
  logic [BWIDTH-1:0]        reg_wdata;
  logic [BWIDTH-1:0]        reg_rdata;
  logic                     img_we;
  logic                     img_rd;
  logic [IMGSIZE-1:0]       img_addr;
  logic signed [DWIDTH-1:0] img_wdata;
  logic signed [DWIDTH-1:0] img_rdata;
  logic                     net_we;
  logic                     net_rd;
  logic [NETSIZE-1:0]       net_addr;
  logic signed [DWIDTH-1:0] net_wdata;
  logic signed [DWIDTH-1:0] net_rdata;
  logic                     core_busy;
  logic [8*16-1:0]          test_name;
  integer                   seed;
  int                       tb_errors;
  int                       err_count;
  int                       check_count;

  kinpira_top uut (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_re    (reg_re),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .img_we    (img_we),
    .img_addr  (img_addr),
    .img_wdata (img_wdata),
    .img_rdata (img_rdata),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .net_rdata (net_rdata)
  );

  assign core_busy = uut.busy;

  kinpira_checker chk (
    .clk         (clk),
    .xrst        (xrst),
    .busy        (core_busy),
    .test_name   (test_name),
    .reg_we      (reg_we),
    .reg_re      (reg_re),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .img_we      (img_we),
    .img_rd      (img_rd),
    .img_addr    (img_addr),
    .img_wdata   (img_wdata),
    .img_rdata   (img_rdata),
    .net_we      (net_we),
    .net_rd      (net_rd),
    .net_addr    (net_addr),
    .net_wdata   (net_wdata),
    .net_rdata   (net_rdata),
    .error_count (err_count),
    .check_count (check_count)
  );

  always #4 clk = ~clk;

  // ========================================
  // Host bus tasks
  // ========================================

  function automatic int layer_cycles(input int tin, input int tout);
    return tout * (tin + 4) + 4;
  endfunction

  function automatic logic signed [DWIDTH-1:0] rand_word(input int range);
    return DWIDTH'($random(seed) % range);
  endfunction

  task automatic reg_write(input int addr, input logic [BWIDTH-1:0] data);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= REGSIZE'(addr);
    reg_wdata <= data;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic reg_read(input int addr, output logic [BWIDTH-1:0] data);
    @(posedge clk);
    reg_re   <= 1'b1;
    reg_addr <= REGSIZE'(addr);
    @(posedge clk);
    reg_re <= 1'b0;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic img_write(input int addr, input logic signed [DWIDTH-1:0] data);
    @(posedge clk);
    img_we    <= 1'b1;
    img_addr  <= IMGSIZE'(addr);
    img_wdata <= data;
    @(posedge clk);
    img_we <= 1'b0;
  endtask

  // Checker compares the word one cycle later
  task automatic img_read(input int addr);
    @(posedge clk);
    img_rd   <= 1'b1;
    img_addr <= IMGSIZE'(addr);
    @(posedge clk);
    img_rd <= 1'b0;
  endtask

  task automatic net_write(input int addr, input logic signed [DWIDTH-1:0] data);
    @(posedge clk);
    net_we    <= 1'b1;
    net_addr  <= NETSIZE'(addr);
    net_wdata <= data;
    @(posedge clk);
    net_we <= 1'b0;
  endtask

  task automatic net_read(input int addr);
    @(posedge clk);
    net_rd   <= 1'b1;
    net_addr <= NETSIZE'(addr);
    @(posedge clk);
    net_rd <= 1'b0;
  endtask

  task automatic set_layer(input int tin, input int tout, input int in_off, input int out_off,
                           input int net_off, input int qb, input bit bias, input bit relu);
    reg_write(REG_BASE, {tout[LWIDTH-1:0], tin[LWIDTH-1:0]});
    reg_write(REG_IN_OFFSET, in_off);
    reg_write(REG_OUT_OFFSET, out_off);
    reg_write(REG_NET_OFFSET, net_off);
    reg_write(REG_QBITS, qb);
    reg_write(REG_BIAS, {bias, 31'd0});
    reg_write(REG_ACTV, {relu, 31'd0});
  endtask

  task automatic load_layer(input int tin, input int tout, input int in_off, input int net_off,
                            input int range);
    for (int i = 0; i < tin; i++) begin
      img_write(in_off + i, rand_word(range));
    end
    for (int i = 0; i < tout * (tin + 1); i++) begin
      net_write(net_off + i, rand_word(range));
    end
  endtask

  // Poll status until ack with busy low
  task automatic wait_done(input int limit);
    logic [BWIDTH-1:0] status;
    int                polls;
    status = '0;
    polls  = 0;
    repeat (2) @(posedge clk);
    while (!(status[0] && !status[1]) && polls < limit) begin
      reg_read(REG_STATUS, status);
      polls++;
    end
    if (!(status[0] && !status[1])) begin
      tb_errors++;
      $display("Layer in test %0s did not finish after %0d status polls", test_name, polls);
    end
  endtask

  task automatic read_outputs(input int out_off, input int tout);
    for (int o = 0; o < tout; o++) begin
      img_read(out_off + o);
    end
  endtask

  // ========================================
  // Tests
  // ========================================

  initial begin : main
    logic [BWIDTH-1:0] rdata;
    int                tin;
    int                tout;
    clk       = 1'b0;
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    img_we    = 1'b0;
    img_rd    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    net_we    = 1'b0;
    net_rd    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    seed      = 7;
    tb_errors = 0;
    test_name = "reset";
    repeat (RST_CYCLES) @(posedge clk);
    xrst <= 1'b1;

    for (int a = 0; a <= REG_STATUS; a++) begin
      reg_read(a, rdata);
    end

    test_name = "readback";
    // Bit 0 stays clear so no layer starts
    for (int a = 0; a < REG_STATUS; a++) begin
      reg_write(a, {a[3:0], 28'h5a3c96e});
    end
    reg_write(REG_STATUS, '1);
    for (int a = 0; a <= REG_STATUS; a++) begin
      reg_read(a, rdata);
    end

    test_name = "plain_dot";
    set_layer(4, 3, 0, 100, 0, 0, 1'b0, 1'b0);
    load_layer(4, 3, 0, 0, 16);
    // Weights back through the network port
    for (int i = 0; i < 3 * 5; i++) begin
      net_read(i);
    end
    reg_write(REG_REQ, 1);
    wait_done(layer_cycles(4, 3));
    read_outputs(100, 3);

    test_name = "bias_relu";
    for (int l = 0; l < 3; l++) begin
      tin  = 2 + ($unsigned($random(seed)) % 7);
      tout = 1 + ($unsigned($random(seed)) % 4);
      set_layer(tin, tout, 300, 400 + l * 8, 200 + l * 48, l * 2, 1'b1, 1'b1);
      load_layer(tin, tout, 300, 200 + l * 48, 16);
      reg_write(REG_REQ, 1);
      wait_done(layer_cycles(8, 4));
      read_outputs(400 + l * 8, tout);
    end

    test_name = "saturate";
    set_layer(3, 2, 500, 600, 1000, 0, 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      img_write(500 + i, 20000);
      net_write(1000 + i, 20000);
      net_write(1004 + i, -20000);
    end
    net_write(1003, 0);
    net_write(1007, 0);
    reg_write(REG_REQ, 1);
    wait_done(layer_cycles(3, 2));
    read_outputs(600, 2);

    test_name = "busy_ignore";
    set_layer(6, 3, 700, 800, 1100, 1, 1'b1, 1'b0);
    load_layer(6, 3, 700, 1100, 16);
    reg_write(REG_REQ, 1);
    repeat (2) @(posedge clk);
    reg_read(REG_STATUS, rdata);
    img_write(700, 1234);
    net_write(1100, 4321);
    reg_write(REG_REQ, 1);
    wait_done(layer_cycles(6, 3));
    read_outputs(800, 3);
    img_read(700);
    net_read(1100);
    repeat (20) @(posedge clk);
    reg_read(REG_STATUS, rdata);
    // A fresh start after ack runs again
    reg_write(REG_REQ, 1);
    wait_done(layer_cycles(6, 3));
    read_outputs(800, 3);

    repeat (4) @(posedge clk);
    $display("Checks %0d, check errors %0d, run errors %0d", check_count, err_count, tb_errors);
    if (err_count == 0 && tb_errors == 0 && check_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from the worst-case layer latencies
  initial begin : watchdog
    int run_cycles;
    run_cycles = layer_cycles(4, 3) + 3 * layer_cycles(8, 4) + layer_cycles(3, 2)
               + 2 * layer_cycles(6, 3);
    repeat (RST_CYCLES + SETUP_CYCLES + 2 * run_cycles) @(posedge clk);
    $display("Timeout: the run did not finish in time, stopped in test %0s", test_name);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/kinpira_pkg.sv
hw/mem_sp.sv
hw/param_regs.sv
gobou/gobou_mac.sv
gobou/gobou_ctrl.sv
hw/kinpira_top.sv
test/kinpira_checker.sv
test/kinpira_tb.sv
